/* src/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

`define LSU_XLEN        32
`define LSU_REG_AW      5
`define LSU_SRAM_WORDS  256

// bit 3 marks a store
`define LSU_OP_ALU      4'h0
`define LSU_OP_LD_W     4'h1
`define LSU_OP_LD_H     4'h2
`define LSU_OP_LD_B     4'h3
`define LSU_OP_LD_HU    4'h4
`define LSU_OP_LD_BU    4'h5
`define LSU_OP_ST_W     4'h8
`define LSU_OP_ST_H     4'h9
`define LSU_OP_ST_B     4'ha

`endif

/* src/lsu_pkg.sv */
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_XLEN-1:0]   addr_t;
    typedef logic [`LSU_REG_AW-1:0] reg_idx_t;
    typedef logic [`LSU_XLEN/8-1:0] byte_en_t;

    typedef enum logic [3:0] {
        op_alu   = `LSU_OP_ALU,
        op_ld_w  = `LSU_OP_LD_W,
        op_ld_h  = `LSU_OP_LD_H,
        op_ld_b  = `LSU_OP_LD_B,
        op_ld_hu = `LSU_OP_LD_HU,
        op_ld_bu = `LSU_OP_LD_BU,
        op_st_w  = `LSU_OP_ST_W,
        op_st_h  = `LSU_OP_ST_H,
        op_st_b  = `LSU_OP_ST_B
    } mem_op_e;

    typedef struct packed {
        mem_op_e  op;
        addr_t    pc;
        word_t    base;
        word_t    offset;
        word_t    wdata;      // alu result when op_alu
        reg_idx_t dest;
        logic     gr_we;
    } issue_t;

    typedef struct packed {
        mem_op_e    op;
        addr_t      pc;
        logic [1:0] addr_low2;
        word_t      result;   // alu result or address
        reg_idx_t   dest;
        logic       gr_we;
    } ex_mem_t;

    typedef struct packed {
        addr_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     gr_we;
    } mem_wb_t;

endpackage

`default_nettype wire

/* src/ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
    input  wire               clk,
    input  wire               resetn,
    input  wire               issue_valid,
    input  wire lsu_pkg::issue_t issue_bus,
    output logic              issue_allowin,
    input  wire               mem_allowin,
    output logic              ex_mem_valid,
    output lsu_pkg::ex_mem_t  ex_mem_bus,
    output logic              sram_en,
    output lsu_pkg::byte_en_t sram_we,
    output lsu_pkg::addr_t    sram_addr,
    output lsu_pkg::word_t    sram_wdata
);
    import lsu_pkg::*;

    logic     ex_valid;
    issue_t   ex_bus;
    addr_t    ex_addr;
    logic     is_load;
    logic     is_store;
    logic     ex_go;
    byte_en_t st_be;
    word_t    st_data;

    assign ex_mem_valid  = ex_valid;
    assign issue_allowin = ~ex_valid | mem_allowin;
    assign ex_go         = ex_mem_valid & mem_allowin; // leaves for mem this cycle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (issue_allowin) begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_allowin) begin
            ex_bus <= issue_bus;
        end
    end

    assign ex_addr  = ex_bus.base + ex_bus.offset;
    assign is_load  = ex_bus.op inside {op_ld_w, op_ld_h, op_ld_b, op_ld_hu, op_ld_bu};
    assign is_store = ex_bus.op inside {op_st_w, op_st_h, op_st_b};

    always_comb begin
        st_be   = '0;
        st_data = ex_bus.wdata;
        case (ex_bus.op)
            op_st_w: st_be = 4'b1111;
            op_st_h: begin
                st_be   = ex_addr[1] ? 4'b1100 : 4'b0011;
                st_data = {2{ex_bus.wdata[15:0]}}; // halfword in both halves
            end
            op_st_b: begin
                st_be   = 4'b0001 << ex_addr[1:0];
                st_data = {4{ex_bus.wdata[7:0]}};  // byte in every lane
            end
            default: st_be = '0;
        endcase
    end

    assign sram_en    = ex_go & (is_load | is_store);
    assign sram_we    = ex_go ? st_be : '0;
    assign sram_addr  = ex_addr;
    assign sram_wdata = st_data;

    assign ex_mem_bus.op        = ex_bus.op;
    assign ex_mem_bus.pc        = ex_bus.pc;
    assign ex_mem_bus.addr_low2 = ex_addr[1:0];
    assign ex_mem_bus.result    = (ex_bus.op == op_alu) ? ex_bus.wdata : ex_addr;
    assign ex_mem_bus.dest      = ex_bus.dest;
    assign ex_mem_bus.gr_we     = ex_bus.gr_we & ~is_store; // stores never write back

endmodule

`default_nettype wire

/* src/data_sram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module data_sram #(
    parameter int depth = `LSU_SRAM_WORDS
) (
    input  wire                    clk,
    input  wire                    en,
    input  wire lsu_pkg::byte_en_t we,
    input  wire lsu_pkg::addr_t    addr,
    input  wire lsu_pkg::word_t    wdata,
    output lsu_pkg::word_t         rdata
);
    import lsu_pkg::*;

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    word_t             mem [depth];
    logic [idx_w-1:0]  idx;

    assign idx = addr[idx_w+1:2]; // word index, byte offset dropped

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // read register holds until the next enabled read
    always_ff @(posedge clk) begin
        if (en && we == '0) begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  ex_mem_valid,
    input  wire lsu_pkg::ex_mem_t ex_mem_bus,
    output logic                 mem_allowin,
    input  wire                  wb_allowin,
    output logic                 mem_wb_valid,
    output lsu_pkg::mem_wb_t     mem_wb_bus,
    input  wire lsu_pkg::word_t  sram_rdata
);
    import lsu_pkg::*;

    logic        mem_valid;
    ex_mem_t     mem_bus;
    logic [15:0] half_data;
    logic [7:0]  byte_data;
    word_t       load_data;
    logic        is_load;

    assign mem_wb_valid = mem_valid;
    assign mem_allowin  = ~mem_valid | wb_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem_valid && mem_allowin) begin
            mem_bus <= ex_mem_bus;
        end
    end

    assign half_data = mem_bus.addr_low2[1] ? sram_rdata[31:16] : sram_rdata[15:0];
    assign byte_data = sram_rdata[mem_bus.addr_low2*8 +: 8];

    always_comb begin
        case (mem_bus.op)
            op_ld_w:  load_data = sram_rdata;
            op_ld_h:  load_data = {{16{half_data[15]}}, half_data};
            op_ld_hu: load_data = {16'b0, half_data};
            op_ld_b:  load_data = {{24{byte_data[7]}}, byte_data};
            default:  load_data = {24'b0, byte_data}; // ld.bu
        endcase
    end

    assign is_load = mem_bus.op inside {op_ld_w, op_ld_h, op_ld_b, op_ld_hu, op_ld_bu};

    assign mem_wb_bus.pc     = mem_bus.pc;
    assign mem_wb_bus.result = is_load ? load_data : mem_bus.result;
    assign mem_wb_bus.dest   = mem_bus.dest;
    assign mem_wb_bus.gr_we  = mem_bus.gr_we;

endmodule

`default_nettype wire

/* src/wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  mem_wb_valid,
    input  wire lsu_pkg::mem_wb_t mem_wb_bus,
    output logic                 wb_allowin,
    input  wire                  retire_allow,
    output logic                 rf_we,
    output lsu_pkg::reg_idx_t    rf_waddr,
    output lsu_pkg::word_t       rf_wdata,
    output lsu_pkg::addr_t       rf_pc
);
    import lsu_pkg::*;

    logic    wb_valid;
    logic    wb_ready_go;
    mem_wb_t wb_bus;

    assign wb_ready_go = retire_allow; // outside can hold retirement
    assign wb_allowin  = ~wb_valid | wb_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid && wb_allowin) begin
            wb_bus <= mem_wb_bus;
        end
    end

    // r0 is hardwired zero
    assign rf_we    = wb_valid & wb_bus.gr_we & (wb_bus.dest != '0);
    assign rf_waddr = wb_bus.dest;
    assign rf_wdata = wb_bus.result;
    assign rf_pc    = wb_bus.pc;

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  issue_valid,
    input  wire lsu_pkg::issue_t issue_bus,
    output logic                 issue_allowin,
    input  wire                  retire_allow,
    output logic                 rf_we,
    output lsu_pkg::reg_idx_t    rf_waddr,
    output lsu_pkg::word_t       rf_wdata,
    output lsu_pkg::addr_t       rf_pc
);
    import lsu_pkg::*;

    logic     mem_allowin;
    logic     wb_allowin;
    logic     ex_mem_valid;
    logic     mem_wb_valid;
    ex_mem_t  ex_mem_bus;
    mem_wb_t  mem_wb_bus;
    logic     sram_en;
    byte_en_t sram_we;
    addr_t    sram_addr;
    word_t    sram_wdata;
    word_t    sram_rdata;

    ex_stage ex_stage_inst (
        .clk           (clk),
        .resetn        (resetn),
        .issue_valid   (issue_valid),
        .issue_bus     (issue_bus),
        .issue_allowin (issue_allowin),
        .mem_allowin   (mem_allowin),
        .ex_mem_valid  (ex_mem_valid),
        .ex_mem_bus    (ex_mem_bus),
        .sram_en       (sram_en),
        .sram_we       (sram_we),
        .sram_addr     (sram_addr),
        .sram_wdata    (sram_wdata)
    );

    data_sram #(
        .depth (`LSU_SRAM_WORDS)
    ) data_sram_inst (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    mem_stage mem_stage_inst (
        .clk          (clk),
        .resetn       (resetn),
        .ex_mem_valid (ex_mem_valid),
        .ex_mem_bus   (ex_mem_bus),
        .mem_allowin  (mem_allowin),
        .wb_allowin   (wb_allowin),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb_bus   (mem_wb_bus),
        .sram_rdata   (sram_rdata)
    );

    wb_stage wb_stage_inst (
        .clk          (clk),
        .resetn       (resetn),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb_bus   (mem_wb_bus),
        .wb_allowin   (wb_allowin),
        .retire_allow (retire_allow),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .rf_pc        (rf_pc)
    );

endmodule

`default_nettype wire

/* sim/lsu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_assert (
    input wire                    clk,
    input wire                    resetn,
    input wire                    issue_allowin,
    input wire                    retire_allow,
    input wire                    rf_we,
    input wire lsu_pkg::reg_idx_t rf_waddr,
    input wire lsu_pkg::word_t    rf_wdata,
    input wire lsu_pkg::addr_t    rf_pc,
    input wire                    ex_mem_valid,
    input wire                    mem_wb_valid,
    input wire                    wb_allowin,
    input wire                    sram_en,
    input wire lsu_pkg::byte_en_t sram_we,
    input wire lsu_pkg::addr_t    sram_addr,
    input wire lsu_pkg::mem_op_e  ex_op
);
    import lsu_pkg::*;

    reset_clears: assert property (@(posedge clk)
        !resetn |=> !rf_we && issue_allowin && !sram_en)
    else $error("outputs not idle after reset");

    // a stalled write-back keeps its port steady
    stall_holds: assert property (@(posedge clk) disable iff (!resetn)
        rf_we && !retire_allow |=> rf_we && $stable(rf_waddr) && $stable(rf_wdata)
            && $stable(rf_pc))
    else $error("register-file write port changed during stall");

    // issue blocks exactly when all three stages hold and write-back is stalled
    full_only: assert property (@(posedge clk) disable iff (!resetn)
        !issue_allowin == (ex_mem_valid && mem_wb_valid && !wb_allowin))
    else $error("issue_allowin does not match a full stalled pipeline");

    we_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        sram_we != '0 |-> sram_en)
    else $error("byte enables without sram enable");

    st_w_shape: assert property (@(posedge clk) disable iff (!resetn)
        sram_en && ex_op == op_st_w |-> sram_we == 4'b1111)
    else $error("st.w byte enables wrong");

    st_h_shape: assert property (@(posedge clk) disable iff (!resetn)
        sram_en && ex_op == op_st_h |-> sram_we == (sram_addr[1] ? 4'b1100 : 4'b0011))
    else $error("st.h byte enables wrong");

    st_b_shape: assert property (@(posedge clk) disable iff (!resetn)
        sram_en && ex_op == op_st_b |-> sram_we == (4'b0001 << sram_addr[1:0]))
    else $error("st.b byte enables wrong");

    load_no_we: assert property (@(posedge clk) disable iff (!resetn)
        sram_en && !(ex_op inside {op_st_w, op_st_h, op_st_b}) |-> sram_we == '0)
    else $error("load drives byte enables");

endmodule

`default_nettype wire

/* sim/lsu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    typedef struct packed {
        addr_t       pc;
        reg_idx_t    dest;
        word_t       data;
        logic        timed;
        logic [31:0] acc;
    } exp_t;

    localparam int n_planned   = 16 + 96 + 84 + 60 + 13;
    localparam int cycle_limit = 2 * n_planned + 200;

    logic     clk;
    logic     resetn;
    logic     issue_valid;
    issue_t   issue_bus;
    logic     issue_allowin;
    logic     retire_allow;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    addr_t    rf_pc;

    logic [31:0] lfsr = 32'h5db0;
    logic [31:0] cycle = 0;
    logic [7:0]  shadow [256];
    exp_t        exp_q [$];
    exp_t        exp_head;
    logic        exp_valid = 1'b0;
    logic        beat = 1'b0;
    logic        stall_on = 1'b0;
    addr_t       pc = 32'h1c00_0000;
    int          errors = 0;
    int          errors_at_start = 0;
    int          passes = 0;
    int          fails = 0;
    mem_op_e     all_ops [9] = '{op_alu, op_ld_w, op_ld_h, op_ld_b, op_ld_hu, op_ld_bu,
                                 op_st_w, op_st_h, op_st_b};

    lsu_top lsu_top_inst (.*);

    bind lsu_top lsu_assert lsu_assert_inst (
        .clk(clk), .resetn(resetn), .issue_allowin(issue_allowin),
        .retire_allow(retire_allow), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata), .rf_pc(rf_pc), .ex_mem_valid(ex_mem_valid),
        .mem_wb_valid(mem_wb_valid), .wb_allowin(wb_allowin),
        .sram_en(sram_en), .sram_we(sram_we),
        .sram_addr(sram_addr), .ex_op(ex_mem_bus.op)
    );

    always #50 clk = ~clk;

    retire_check: assert property (@(posedge clk) disable iff (!resetn)
        rf_we && retire_allow |-> exp_valid && rf_waddr == exp_head.dest
            && rf_wdata == exp_head.data && rf_pc == exp_head.pc)
    else begin
        errors++;
        $display("ERROR %0t: retired r%0d=%h pc %h, expected r%0d=%h pc %h (valid %0b)",
                 $time, $sampled(rf_waddr), $sampled(rf_wdata), $sampled(rf_pc),
                 $sampled(exp_head.dest), $sampled(exp_head.data), $sampled(exp_head.pc),
                 $sampled(exp_valid));
    end

    latency_check: assert property (@(posedge clk) disable iff (!resetn)
        rf_we && retire_allow && exp_valid && exp_head.timed |-> cycle == exp_head.acc + 3)
    else begin
        errors++;
        $display("ERROR %0t: pc %h retired at cycle %0d, accepted at %0d",
                 $time, $sampled(rf_pc), $sampled(cycle), $sampled(exp_head.acc));
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lfsr_bits(8);
        return r[7:0];
    endfunction

    function automatic logic [7:0] word_addr();
        logic [31:0] r;
        r = lfsr_bits(6);
        return {r[5:0], 2'b00};
    endfunction

    function automatic reg_idx_t rand_dest();
        logic [31:0] r;
        r = lfsr_bits(5);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    endfunction

    // little-endian view of the shadow memory
    function automatic word_t load_value(input mem_op_e op, input logic [7:0] a);
        logic [7:0]  wa;
        logic [7:0]  ha;
        logic [7:0]  b;
        logic [15:0] h;
        wa = {a[7:2], 2'b00};
        ha = {a[7:1], 1'b0};
        b  = shadow[a];
        h  = {shadow[ha + 8'd1], shadow[ha]};
        case (op)
            op_ld_w:  return {shadow[wa + 8'd3], shadow[wa + 8'd2], shadow[wa + 8'd1], shadow[wa]};
            op_ld_h:  return {{16{h[15]}}, h};
            op_ld_hu: return {16'b0, h};
            op_ld_b:  return {{24{b[7]}}, b};
            default:  return {24'b0, b};
        endcase
    endfunction

    function automatic void store_shadow(input mem_op_e op, input logic [7:0] a, input word_t d);
        logic [7:0] wa;
        wa = {a[7:2], 2'b00};
        case (op)
            op_st_w: begin
                for (int i = 0; i < 4; i++) shadow[wa + 8'(i)] = d[i*8 +: 8];
            end
            op_st_h: begin
                shadow[{a[7:1], 1'b0}] = d[7:0];
                shadow[{a[7:1], 1'b1}] = d[15:8];
            end
            default: shadow[a] = d[7:0];
        endcase
    endfunction

    function automatic void refresh_head();
        exp_valid = exp_q.size() != 0;
        exp_head  = exp_valid ? exp_q[0] : '0;
    endfunction

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        r = lfsr_bits(1);
        retire_allow = stall_on ? r[0] : 1'b1;
    endtask

    task automatic issue(input mem_op_e op, input logic [7:0] target, input word_t wdata,
                         input reg_idx_t dest, input logic gr_we);
        exp_t        e;
        logic [31:0] base;
        logic        is_st;
        base    = lfsr_bits(8);
        is_st   = op inside {op_st_w, op_st_h, op_st_b};
        e.pc    = pc;
        e.dest  = dest;
        e.timed = ~stall_on;
        e.data  = (op == op_alu) ? wdata : load_value(op, target);
        if (is_st) store_shadow(op, target, wdata);
        next_cycle();
        issue_valid = 1'b1;
        issue_bus   = '{op: op, pc: pc, base: base, offset: {24'b0, target} - base,
                        wdata: wdata, dest: dest, gr_we: gr_we};
        #10;
        while (!issue_allowin) begin
            next_cycle();
            #10;
        end
        e.acc = cycle;                           // taken on the coming edge
        if (gr_we && !is_st && dest != '0) begin
            exp_q.push_back(e);
            refresh_head();
        end
        pc = pc + 32'd4;
    endtask

    task automatic drain();
        next_cycle();
        issue_valid = 1'b0;
        while (exp_q.size() != 0) next_cycle();
        repeat (4) next_cycle();
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            passes++;
            $display("test %s: pass", name);
        end else begin
            fails++;
            $display("test %s: fail, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    always @(negedge clk) begin
        #45;
        beat = resetn && rf_we && retire_allow;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (beat && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [7:0] w;
        logic [7:0] b;
        clk          = 1'b0;
        resetn       = 1'b0;
        issue_valid  = 1'b0;
        issue_bus    = '0;
        retire_allow = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        repeat (6) next_cycle();
        finish_test("reset state");

        for (int i = 0; i < 16; i++) issue(op_alu, rand_byte(), lfsr_bits(32), rand_dest(), 1'b1);
        drain();
        finish_test("alu pass-through");

        for (int i = 0; i < 64; i++) issue(op_st_w, 8'(i * 4), lfsr_bits(32), 5'd0, 1'b0);
        for (int i = 0; i < 16; i++) begin
            w = word_addr();
            issue(op_st_w, w, lfsr_bits(32), rand_dest(), 1'b0);
            issue(op_ld_w, w, '0, rand_dest(), 1'b1);
        end
        drain();
        finish_test("word store and load");

        for (int i = 0; i < 6; i++) begin
            w = word_addr();
            b = rand_byte();
            issue(op_st_b, w + {6'b0, b[1:0]}, lfsr_bits(32), rand_dest(), 1'b0);
            for (int k = 0; k < 4; k++) begin
                issue(op_ld_b, w + 8'(k), '0, rand_dest(), 1'b1);
                issue(op_ld_bu, w + 8'(k), '0, rand_dest(), 1'b1);
            end
            issue(op_st_h, w + {6'b0, b[2], 1'b0}, lfsr_bits(32), rand_dest(), 1'b0);
            for (int k = 0; k < 4; k += 2) begin
                issue(op_ld_h, w + 8'(k), '0, rand_dest(), 1'b1);
                issue(op_ld_hu, w + 8'(k), '0, rand_dest(), 1'b1);
            end
        end
        drain();
        finish_test("sub-word access");

        stall_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            issue(all_ops[lfsr_bits(4) % 9], rand_byte(), lfsr_bits(32), rand_dest(), 1'b1);
        end
        drain();
        stall_on = 1'b0;
        finish_test("back-pressure");

        for (int i = 0; i < 4; i++) issue(all_ops[1 + lfsr_bits(3) % 5], rand_byte(), '0, 5'd0, 1'b1);
        for (int i = 0; i < 4; i++) issue(op_alu, rand_byte(), lfsr_bits(32), 5'd0, 1'b1);
        for (int i = 0; i < 4; i++) issue(all_ops[6 + lfsr_bits(2) % 3], rand_byte(),
                                          lfsr_bits(32), rand_dest(), 1'b1);
        issue(op_alu, rand_byte(), lfsr_bits(32), rand_dest(), 1'b1);
        drain();
        finish_test("zero register");

        $display("tests passed %0d, failed %0d", passes, fails);
        if (fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/lsu_pkg.sv
src/ex_stage.sv
src/data_sram.sv
src/mem_stage.sv
src/wb_stage.sv
src/lsu_top.sv
sim/lsu_assert.sv
sim/lsu_tb.sv

/* Makefile */
TOP = lsu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "TB PASSED" > /dev/null

clean:
	rm -rf obj_dir
